//--- dv/eepromTb.sv
`default_nettype none

module eepromTb
   import eepromPkg::*;
();

   localparam int          MemAddrWidth     = 15;
   localparam int          PageBytes        = 64;
   localparam int          WriteCycleClocks = 16;
   localparam int          CycleLimit       = 20000;
   localparam int          StatusPolls      = 40;   // Longest busy is about 5 polls
   localparam int unsigned Seed             = 32'h5570_41d0;

   typedef logic [ByteWidth-1:0] byteQueueT [$];

   logic SCK;
   logic RstWriteEnable;
   logic CsN;
   logic Si;
   logic WpN;
   logic HoldN;
   logic So;
   logic SoEnable;

   logic [ByteWidth-1:0] refMem [int];           // Every byte the array should hold
   logic                 modelWel;
   logic                 modelWpen;
   blockProtectT         modelBp;
   int                   errorCount = 0;
   int                   checkCount = 0;
   int                   cycleCount = 0;

   eepromTop #(
      .MemAddrWidth(MemAddrWidth), .PageBytes(PageBytes),
      .WriteCycleClocks(WriteCycleClocks)
   ) u_eepromTop (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .CsN(CsN), .Si(Si), .WpN(WpN),
      .HoldN(HoldN), .So(So), .SoEnable(SoEnable)
   );

   initial begin
      SCK = 1'b0;
      forever #5 SCK = ~SCK;
   end

   always @(posedge SCK) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == CycleLimit) begin
         $display("Timeout: tests still running after %0d cycles", CycleLimit);
         $display("TEST FAIL");
         $finish;
      end
   end

   HoldDropsSoEnable: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      !HoldN |-> !SoEnable)
      else begin
         errorCount++;
         $display("[FAIL] SoEnable = %h while HoldN low, expected 0", SoEnable);
      end

   // Output must be off once the frame has closed
   IdleDropsSoEnable: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      CsN && $past(CsN) |-> !SoEnable)
      else begin
         errorCount++;
         $display("[FAIL] SoEnable = %h with CsN high, expected 0", SoEnable);
      end

   function automatic byteQueueT randomBytes(input int count);
      byteQueueT bytes;
      for (int i = 0; i < count; i++)
         bytes.push_back(8'($urandom_range(0, 255)));
      return bytes;
   endfunction

   // Locked regions are the top quarter, the top half or everything
   function automatic logic isLocked(input int pageBase);
      int arrayBytes;
      arrayBytes = 1 << MemAddrWidth;
      case (modelBp)
         BpQuarter: return pageBase >= arrayBytes - arrayBytes / 4;
         BpHalf:    return pageBase >= arrayBytes / 2;
         BpAll:     return 1'b1;
         default:   return 1'b0;
      endcase
   endfunction

   // So is sampled as it stood before the edge that takes bitIn
   task automatic stepBit(input logic bitIn, output logic bitOut);
      bitOut = So;
      CsN    = 1'b0;
      Si     = bitIn;
      @(posedge SCK);
      #1;
   endtask

   task automatic sendByte(input logic [ByteWidth-1:0] value,
                           output logic [ByteWidth-1:0] echo);
      logic bitOut;
      for (int i = ByteWidth - 1; i >= 0; i--) begin
         stepBit(value[i], bitOut);
         echo[i] = bitOut;
      end
   endtask

   task automatic holdBus(input int cycles);
      HoldN = 1'b0;
      repeat (cycles) begin
         @(posedge SCK);
         #1;
         checkCount++;
         assert (SoEnable === 1'b0) else begin
            errorCount++;
            $display("[FAIL] SoEnable = %h during hold, expected 0", SoEnable);
         end
      end
      HoldN = 1'b1;
      #1;                                        // Let SoEnable settle
   endtask

   task automatic receiveByte(output logic [ByteWidth-1:0] value, input logic pauseInside);
      logic bitOut;
      for (int i = ByteWidth - 1; i >= 0; i--) begin
         if (pauseInside && i == 3)
            holdBus(6);                          // Pause mid-byte
         checkCount++;
         assert (SoEnable === 1'b1) else begin
            errorCount++;
            $display("[FAIL] SoEnable = %h during read data, expected 1", SoEnable);
         end
         stepBit(1'b0, bitOut);
         value[i] = bitOut;
      end
   endtask

   task automatic closeFrame();
      CsN = 1'b1;
      Si  = 1'b0;
      repeat (2) @(posedge SCK);
      #1;
   endtask

   task automatic sendCommand(input opcodeT op);
      logic [ByteWidth-1:0] unused;
      sendByte(op, unused);
      closeFrame();
      if (op == OpWren)
         modelWel = 1'b1;
      else if (op == OpWrdi)
         modelWel = 1'b0;
   endtask

   task automatic readStatus(output logic [ByteWidth-1:0] value);
      logic [ByteWidth-1:0] unused;
      sendByte(OpRdsr, unused);
      receiveByte(value, 1'b0);
      closeFrame();
   endtask

   task automatic checkStatus(input logic [ByteWidth-1:0] expected);
      logic [ByteWidth-1:0] value;
      readStatus(value);
      checkCount++;
      assert (value === expected) else begin
         errorCount++;
         $display("[FAIL] RDSR status = %h, expected %h", value, expected);
      end
   endtask

   task automatic waitIdle();
      logic [ByteWidth-1:0] value;
      int                   polls;
      polls = 0;
      readStatus(value);
      while (value[StatusWipBit] === 1'b1 && polls < StatusPolls) begin
         polls++;
         readStatus(value);
      end
      checkCount++;
      assert (value[StatusWipBit] === 1'b0) else begin
         errorCount++;
         $display("Write cycle never ended, busy bit still set after %0d polls", polls);
      end
   endtask

   task automatic writeStatus(input logic [ByteWidth-1:0] value);
      logic [ByteWidth-1:0] unused;
      sendByte(OpWrsr, unused);
      sendByte(value, unused);
      closeFrame();
      if (modelWel && (!modelWpen || WpN)) begin
         modelWpen = value[StatusWpenBit];
         modelBp   = blockProtectT'(value[StatusBp1Bit:StatusBp0Bit]);
      end
      modelWel = 1'b0;
   endtask

   task automatic writePage(input int addr, input byteQueueT data);
      logic [ByteWidth-1:0] unused;
      int                   pageBase;
      int                   target;
      pageBase = addr - (addr % PageBytes);
      sendByte(OpWrite, unused);
      sendByte(8'(addr >> 8), unused);
      sendByte(8'(addr), unused);
      foreach (data[i])
         sendByte(data[i], unused);
      closeFrame();
      if (modelWel && !isLocked(pageBase)) begin
         foreach (data[i]) begin
            target         = pageBase + (addr + i) % PageBytes;   // Offset wraps in page
            refMem[target] = data[i];
         end
      end
      modelWel = 1'b0;
   endtask

   task automatic readBack(input int addr, input int count, input int holdAt);
      logic [ByteWidth-1:0] unused;
      logic [ByteWidth-1:0] value;
      int                   target;
      sendByte(OpRead, unused);
      sendByte(8'(addr >> 8), unused);
      sendByte(8'(addr), unused);
      for (int n = 0; n < count; n++) begin
         receiveByte(value, n == holdAt);
         target = (addr + n) % (1 << MemAddrWidth);
         checkCount++;
         if (!refMem.exists(target)) begin
            errorCount++;
            $display("Address 0x%h was read before anything was written there", target);
         end else begin
            assert (value === refMem[target]) else begin
               errorCount++;
               $display("[FAIL] So byte at 0x%h = %h, expected %h",
                        target, value, refMem[target]);
            end
         end
      end
      closeFrame();
   endtask

   initial begin
      int pageA;
      int pageB;
      CsN            = 1'b1;
      Si             = 1'b0;
      WpN            = 1'b1;
      HoldN          = 1'b1;
      RstWriteEnable = 1'b1;
      modelWel       = 1'b0;
      modelWpen      = 1'b0;
      modelBp        = BpNone;
      void'($urandom(Seed));
      repeat (4) @(posedge SCK);
      #1;
      RstWriteEnable = 1'b0;
      repeat (2) @(posedge SCK);
      #1;

      // Write enable latch
      checkStatus(8'h00);
      sendCommand(OpWren);
      checkStatus(8'h02);
      sendCommand(OpWrdi);
      checkStatus(8'h00);

      // Page writes, wrapping and overlong
      pageA = $urandom_range(0, 99) * PageBytes;
      pageB = $urandom_range(100, 199) * PageBytes;
      sendCommand(OpWren);
      writePage(pageA + 50, randomBytes(20));
      waitIdle();
      readBack(pageA + 50, 14, -1);
      readBack(pageA, 6, -1);
      sendCommand(OpWren);
      writePage(pageB + $urandom_range(1, PageBytes - 1), randomBytes(PageBytes + 6));
      waitIdle();
      readBack(pageB, PageBytes, -1);
      checkStatus(8'h00);

      // No WREN, no write cycle
      writePage(pageB + 8, randomBytes(8));
      checkStatus(8'h00);
      readBack(pageB, PageBytes, -1);

      // Quarter protection
      sendCommand(OpWren);
      writePage('h6100, randomBytes(8));
      waitIdle();
      sendCommand(OpWren);
      writeStatus(8'h04);
      waitIdle();
      checkStatus(8'h04);
      sendCommand(OpWren);
      writePage('h6100, randomBytes(8));
      checkStatus(8'h04);                       // Busy bit never rose
      readBack('h6100, 8, -1);
      sendCommand(OpWren);
      writePage('h5FC0, randomBytes(PageBytes));
      waitIdle();
      readBack('h5FC0, PageBytes, -1);

      // WpN against WpEnable
      sendCommand(OpWren);
      writeStatus(8'h84);
      waitIdle();
      checkStatus(8'h84);
      WpN = 1'b0;
      sendCommand(OpWren);
      checkStatus(8'h86);
      writeStatus(8'h00);
      checkStatus(8'h84);
      WpN = 1'b1;
      sendCommand(OpWren);
      writeStatus(8'h00);
      waitIdle();
      checkStatus(8'h00);

      // Sequential read over a page edge with a hold
      sendCommand(OpWren);
      writePage('h1FC0, randomBytes(PageBytes));
      waitIdle();
      sendCommand(OpWren);
      writePage('h2000, randomBytes(16));
      waitIdle();
      readBack('h1FF8, 20, 3);

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
src/eepromPkg.sv
src/serialFrontEnd.sv
src/statusRegister.sv
src/pageBuffer.sv
src/arrayController.sv
src/outputShifter.sv
src/eepromTop.sv
dv/eepromTb.sv

//--- run.sh
#!/bin/sh
# Build and run the EEPROM testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module eepromTb \
   -f project.f --Mdir obj_dir -o eepromSim \
   && ./obj_dir/eepromSim | tee sim.log
grep -qx "TEST PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- src/arrayController.sv
`default_nettype none

module arrayController
   import eepromPkg::*;
#(
   parameter int  MemAddrWidth     = 15,
   parameter int  PageBytes        = 64,
   parameter int  WriteCycleClocks = 16,
   localparam int IndexWidth       = $clog2(PageBytes),
   localparam int TimerWidth       = $clog2(WriteCycleClocks + 1)
)(
   input  wire                      SCK,
   input  wire                      RstWriteEnable,
   input  wire                      PageWriteStart,
   input  wire                      StatusWriteStart,
   input  wire [FrameAddrWidth-1:0] Address,
   input  wire blockProtectT        BlockProtect,
   input  wire [ByteWidth-1:0]      BufData,
   input  wire [IndexWidth:0]       ByteCount,
   input  wire [MemAddrWidth-1:0]   ReadAddress,
   output logic                     WriteActive,
   output logic [IndexWidth-1:0]    BufIndex,
   output logic [ByteWidth-1:0]     ReadData
);

   typedef enum logic [1:0] {
      StIdle,
      StCopy,
      StHold
   } stateT;

   stateT                              state;
   logic [MemAddrWidth-IndexWidth-1:0] pageNum;       // Page of the pending write
   logic [IndexWidth-1:0]              startOffset;
   logic [IndexWidth:0]                copyCount;
   logic [TimerWidth-1:0]              holdCount;
   logic [MemAddrWidth-1:0]            startBase;
   logic [MemAddrWidth-1:0]            writeAddr;
   logic                               memWrite;
   logic [ByteWidth-1:0]               memArray [2**MemAddrWidth];

   function automatic logic isProtected(input logic [MemAddrWidth-1:0] addr,
                                        input blockProtectT bp);
      case (bp)
         BpQuarter: return addr[MemAddrWidth-1] && addr[MemAddrWidth-2];
         BpHalf:    return addr[MemAddrWidth-1];
         BpAll:     return 1'b1;
         default:   return 1'b0;
      endcase
   endfunction

   // Regions are page aligned, so the base decides for the whole page
   assign startBase   = {Address[MemAddrWidth-1:IndexWidth], {IndexWidth{1'b0}}};
   assign WriteActive = (state != StIdle);
   assign BufIndex    = copyCount[IndexWidth-1:0];
   assign writeAddr   = {pageNum, startOffset + BufIndex};     // Wraps inside the page
   assign memWrite    = (state == StCopy) && (copyCount < ByteCount);
   assign ReadData    = memArray[ReadAddress];

   always_ff @(posedge SCK or posedge RstWriteEnable) begin
      if (RstWriteEnable) begin
         state     <= StIdle;
         copyCount <= '0;
         holdCount <= '0;
      end else begin
         case (state)
            StIdle: begin
               copyCount <= '0;
               holdCount <= '0;
               if (StatusWriteStart)
                  state <= StHold;
               else if (PageWriteStart && !isProtected(startBase, BlockProtect))
                  state <= StCopy;
            end
            StCopy: begin
               if (memWrite)
                  copyCount <= copyCount + 1'b1;        // One byte per clock
               else
                  state <= StHold;
            end
            default: begin
               holdCount <= holdCount + 1'b1;
               if (holdCount == TimerWidth'(WriteCycleClocks - 1))
                  state <= StIdle;
            end
         endcase
      end
   end

   always_ff @(posedge SCK) begin
      if (PageWriteStart && state == StIdle) begin
         pageNum     <= Address[MemAddrWidth-1:IndexWidth];
         startOffset <= Address[IndexWidth-1:0];
      end
      if (memWrite)
         memArray[writeAddr] <= BufData;
   end

   // Status cannot change mid-copy, so every byte must stay outside the lock
   NoProtectedWrite: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      memWrite |-> !isProtected(writeAddr, BlockProtect));

endmodule

`default_nettype wire

//--- src/eepromPkg.sv
`default_nettype none

package eepromPkg;

   localparam int ByteWidth      = 8;
   localparam int FrameAddrWidth = 16;    // Address field of a frame
   localparam int BitCountWidth  = 32;

   // First byte of every frame
   typedef enum logic [ByteWidth-1:0] {
      OpWrsr  = 8'h01,
      OpWrite = 8'h02,
      OpRead  = 8'h03,
      OpWrdi  = 8'h04,
      OpRdsr  = 8'h05,
      OpWren  = 8'h06
   } opcodeT;

   // Upper part of the array that is locked
   typedef enum logic [1:0] {
      BpNone    = 2'b00,
      BpQuarter = 2'b01,
      BpHalf    = 2'b10,
      BpAll     = 2'b11
   } blockProtectT;

   localparam int StatusWipBit  = 0;      // Write cycle in progress
   localparam int StatusWelBit  = 1;      // Write enable latch
   localparam int StatusBp0Bit  = 2;
   localparam int StatusBp1Bit  = 3;
   localparam int StatusWpenBit = 7;      // WpN pin honoured

endpackage

`default_nettype wire

//--- src/eepromTop.sv
`default_nettype none

module eepromTop
   import eepromPkg::*;
#(
   parameter int  MemAddrWidth     = 15,
   parameter int  PageBytes        = 64,
   parameter int  WriteCycleClocks = 16,
   localparam int IndexWidth       = $clog2(PageBytes)
)(
   input  wire  SCK,
   input  wire  RstWriteEnable,
   input  wire  CsN,
   input  wire  Si,
   input  wire  WpN,
   input  wire  HoldN,
   output logic So,
   output logic SoEnable
);

   opcodeT                    opcode;
   blockProtectT              blockProtect;
   logic [FrameAddrWidth-1:0] address;
   logic [ByteWidth-1:0]      dataByte;
   logic                      dataByteValid;
   logic                      readLoad;
   logic                      frameStart;
   logic                      frameEnd;
   logic [BitCountWidth-1:0]  bitCount;
   logic                      writeEnable;
   logic                      wpEnable;
   logic                      pageWriteStart;
   logic                      statusWriteStart;
   logic                      writeActive;
   logic [ByteWidth-1:0]      readData;
   logic [IndexWidth-1:0]     bufIndex;
   logic [ByteWidth-1:0]      bufData;
   logic [IndexWidth:0]       byteCount;
   logic [MemAddrWidth-1:0]   readAddress;

   serialFrontEnd u_serialFrontEnd (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .CsN(CsN), .HoldN(HoldN), .Si(Si),
      .Opcode(opcode), .Address(address), .DataByte(dataByte),
      .DataByteValid(dataByteValid), .ReadLoad(readLoad),
      .FrameStart(frameStart), .FrameEnd(frameEnd), .BitCount(bitCount)
   );

   statusRegister u_statusRegister (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .WpN(WpN), .FrameEnd(frameEnd),
      .WriteActive(writeActive), .Opcode(opcode), .BitCount(bitCount),
      .DataByte(dataByte), .WriteEnable(writeEnable), .WpEnable(wpEnable),
      .PageWriteStart(pageWriteStart), .StatusWriteStart(statusWriteStart),
      .BlockProtect(blockProtect)
   );

   pageBuffer #(.PageBytes(PageBytes)) u_pageBuffer (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .FrameStart(frameStart),
      .DataByteValid(dataByteValid), .WriteEnable(writeEnable),
      .WriteActive(writeActive), .DataByte(dataByte), .BufIndex(bufIndex),
      .BufData(bufData), .ByteCount(byteCount)
   );

   arrayController #(
      .MemAddrWidth(MemAddrWidth), .PageBytes(PageBytes),
      .WriteCycleClocks(WriteCycleClocks)
   ) u_arrayController (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .PageWriteStart(pageWriteStart),
      .StatusWriteStart(statusWriteStart), .Address(address),
      .BlockProtect(blockProtect), .BufData(bufData), .ByteCount(byteCount),
      .ReadAddress(readAddress), .WriteActive(writeActive), .BufIndex(bufIndex),
      .ReadData(readData)
   );

   outputShifter #(.MemAddrWidth(MemAddrWidth)) u_outputShifter (
      .SCK(SCK), .RstWriteEnable(RstWriteEnable), .HoldN(HoldN), .CsN(CsN),
      .ReadLoad(readLoad), .FrameEnd(frameEnd), .WriteActive(writeActive),
      .WriteEnable(writeEnable), .WpEnable(wpEnable), .Opcode(opcode),
      .Address(address), .BlockProtect(blockProtect), .ReadData(readData),
      .ReadAddress(readAddress), .So(So), .SoEnable(SoEnable)
   );

endmodule

`default_nettype wire

//--- src/outputShifter.sv
`default_nettype none

module outputShifter
   import eepromPkg::*;
#(
   parameter int MemAddrWidth = 15
)(
   input  wire                      SCK,
   input  wire                      RstWriteEnable,
   input  wire                      HoldN,
   input  wire                      CsN,
   input  wire                      ReadLoad,
   input  wire                      FrameEnd,
   input  wire                      WriteActive,
   input  wire                      WriteEnable,
   input  wire                      WpEnable,
   input  wire opcodeT              Opcode,
   input  wire [FrameAddrWidth-1:0] Address,
   input  wire blockProtectT        BlockProtect,
   input  wire [ByteWidth-1:0]      ReadData,
   output logic [MemAddrWidth-1:0]  ReadAddress,
   output logic                     So,
   output logic                     SoEnable
);

   logic                    shiftStep;
   logic                    readLoad;
   logic                    statusLoad;
   logic                    soActive;
   logic                    readStarted;   // Pointer now holds the next address
   logic [MemAddrWidth-1:0] readPtr;
   logic [ByteWidth-1:0]    statusByte;
   logic [ByteWidth-1:0]    shiftQ;

   assign shiftStep   = !CsN && HoldN;
   assign readLoad    = ReadLoad && (Opcode == OpRead) && !WriteActive;
   assign statusLoad  = ReadLoad && (Opcode == OpRdsr);
   assign ReadAddress = readStarted ? readPtr : Address[MemAddrWidth-1:0];
   assign So          = shiftQ[ByteWidth-1];
   assign SoEnable    = soActive && HoldN;

   always_comb begin
      statusByte                            = '0;
      statusByte[StatusWpenBit]             = WpEnable;
      statusByte[StatusBp1Bit:StatusBp0Bit] = BlockProtect;
      statusByte[StatusWelBit]              = WriteEnable;
      statusByte[StatusWipBit]              = WriteActive;
   end

   always_ff @(posedge SCK or posedge RstWriteEnable) begin
      if (RstWriteEnable) begin
         soActive    <= 1'b0;
         readStarted <= 1'b0;
      end else if (FrameEnd) begin
         soActive    <= 1'b0;
         readStarted <= 1'b0;
      end else begin
         if (readLoad || statusLoad)
            soActive <= 1'b1;
         if (readLoad)
            readStarted <= 1'b1;
      end
   end

   always_ff @(posedge SCK) begin
      if (readLoad) begin
         shiftQ  <= ReadData;
         readPtr <= ReadAddress + 1'b1;       // Wraps across the whole array
      end else if (statusLoad) begin
         shiftQ <= statusByte;
      end else if (shiftStep) begin
         shiftQ <= {shiftQ[ByteWidth-2:0], 1'b0};
      end
   end

   HoldSilencesSo: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      !HoldN |-> !SoEnable);

endmodule

`default_nettype wire

//--- src/pageBuffer.sv
`default_nettype none

module pageBuffer
   import eepromPkg::*;
#(
   parameter int  PageBytes  = 64,
   localparam int IndexWidth = $clog2(PageBytes)
)(
   input  wire                    SCK,
   input  wire                    RstWriteEnable,
   input  wire                    FrameStart,
   input  wire                    DataByteValid,
   input  wire                    WriteEnable,
   input  wire                    WriteActive,
   input  wire [ByteWidth-1:0]    DataByte,
   input  wire [IndexWidth-1:0]   BufIndex,
   output logic [ByteWidth-1:0]   BufData,
   output logic [IndexWidth:0]    ByteCount
);

   logic [ByteWidth-1:0]  bufMem [PageBytes];
   logic [IndexWidth-1:0] writePtr;
   logic                  takeByte;

   assign takeByte = DataByteValid && WriteEnable && !WriteActive;
   assign BufData  = bufMem[BufIndex];        // Read by the commit sequence

   always_ff @(posedge SCK or posedge RstWriteEnable) begin
      if (RstWriteEnable) begin
         writePtr  <= '0;
         ByteCount <= '0;
      end else if (FrameStart && !WriteActive) begin
         writePtr  <= '0;
         ByteCount <= '0;
      end else if (takeByte) begin
         if (writePtr == IndexWidth'(PageBytes - 1))
            writePtr <= '0;                   // Later bytes overwrite earlier ones
         else
            writePtr <= writePtr + 1'b1;
         if (ByteCount != (IndexWidth + 1)'(PageBytes))
            ByteCount <= ByteCount + 1'b1;
      end
   end

   always_ff @(posedge SCK) begin
      if (takeByte)
         bufMem[writePtr] <= DataByte;
   end

   CountBounded: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      ByteCount <= PageBytes);

endmodule

`default_nettype wire

//--- src/serialFrontEnd.sv
`default_nettype none

module serialFrontEnd
   import eepromPkg::*;
(
   input  wire                       SCK,
   input  wire                       RstWriteEnable,
   input  wire                       CsN,
   input  wire                       HoldN,
   input  wire                       Si,
   output opcodeT                    Opcode,
   output logic [FrameAddrWidth-1:0] Address,
   output logic [ByteWidth-1:0]      DataByte,
   output logic                      DataByteValid,
   output logic                      ReadLoad,
   output logic                      FrameStart,
   output logic                      FrameEnd,
   output logic [BitCountWidth-1:0]  BitCount
);

   logic [FrameAddrWidth-1:0] shiftQ;      // Last 16 bits taken from Si
   logic [FrameAddrWidth-1:0] shiftNext;
   logic                      csNQ;
   logic                      shiftStep;
   logic [BitCountWidth-1:0]  stepCount;   // Steps taken before this edge
   logic                      byteStep;
   opcodeT                    opcodeQ;
   logic [FrameAddrWidth-1:0] addressQ;

   assign shiftStep  = !CsN && HoldN;
   assign FrameStart = csNQ && !CsN;
   assign FrameEnd   = !csNQ && CsN;
   assign stepCount  = FrameStart ? '0 : BitCount;
   assign shiftNext  = {shiftQ[FrameAddrWidth-2:0], Si};
   assign byteStep   = shiftStep && (stepCount[2:0] == 3'd7);

   // Fields show up on the outputs already in the cycle that completes them
   assign Opcode   = (shiftStep && stepCount == 7) ? opcodeT'(shiftNext[ByteWidth-1:0]) : opcodeQ;
   assign Address  = (shiftStep && stepCount == 23) ? shiftNext : addressQ;
   assign DataByte = shiftStep ? shiftNext[ByteWidth-1:0] : shiftQ[ByteWidth-1:0];

   assign DataByteValid = byteStep && (Opcode == OpWrite) && (stepCount >= 31);

   // READ data from step 24 on, status from step 8 on
   assign ReadLoad = byteStep &&
                     (((Opcode == OpRead) && (stepCount >= 23)) || (Opcode == OpRdsr));

   always_ff @(posedge SCK or posedge RstWriteEnable) begin
      if (RstWriteEnable) begin
         csNQ     <= 1'b1;                    // Bus idle
         BitCount <= '0;
      end else begin
         csNQ <= CsN;
         if (shiftStep)
            BitCount <= stepCount + 1'b1;
         else if (FrameStart)
            BitCount <= '0;                   // Frame opened during hold
      end
   end

   always_ff @(posedge SCK) begin
      if (shiftStep)
         shiftQ <= shiftNext;
      opcodeQ  <= Opcode;
      addressQ <= Address;
   end

   // Once the instruction byte is in, it holds until CsN rises
   OpcodeStable: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      (!CsN && !FrameStart && BitCount >= 8) |=> $stable(Opcode));

endmodule

`default_nettype wire

//--- src/statusRegister.sv
`default_nettype none

module statusRegister
   import eepromPkg::*;
(
   input  wire                      SCK,
   input  wire                      RstWriteEnable,
   input  wire                      WpN,
   input  wire                      FrameEnd,
   input  wire                      WriteActive,
   input  wire opcodeT              Opcode,
   input  wire [BitCountWidth-1:0]  BitCount,
   input  wire [ByteWidth-1:0]      DataByte,
   output logic                     WriteEnable,
   output logic                     WpEnable,
   output logic                     PageWriteStart,
   output logic                     StatusWriteStart,
   output blockProtectT             BlockProtect
);

   logic frameDone;          // Frame closed with no write cycle running
   logic wrenGrant;
   logic wrdiGrant;
   logic wrsrGrant;
   logic statusWritable;

   assign frameDone = FrameEnd && !WriteActive;
   assign wrenGrant = frameDone && (Opcode == OpWren) && (BitCount == 8);
   assign wrdiGrant = frameDone && (Opcode == OpWrdi) && (BitCount == 8);
   assign wrsrGrant = frameDone && (Opcode == OpWrsr) && (BitCount == 16) && WriteEnable;

   // WpN only counts once WpEnable is set
   assign statusWritable   = !WpEnable || WpN;
   assign StatusWriteStart = wrsrGrant && statusWritable;

   // Whole bytes only, at least one data byte after the address
   assign PageWriteStart = frameDone && (Opcode == OpWrite) && (BitCount >= 32) &&
                           (BitCount[2:0] == 3'd0) && WriteEnable;

   always_ff @(posedge SCK or posedge RstWriteEnable) begin
      if (RstWriteEnable) begin
         WriteEnable  <= 1'b0;
         WpEnable     <= 1'b0;
         BlockProtect <= BpNone;
      end else begin
         if (wrenGrant)
            WriteEnable <= 1'b1;
         else if (wrdiGrant || wrsrGrant || PageWriteStart)
            WriteEnable <= 1'b0;              // Any granted write uses up the latch
         if (StatusWriteStart) begin
            WpEnable     <= DataByte[StatusWpenBit];
            BlockProtect <= blockProtectT'(DataByte[StatusBp1Bit:StatusBp0Bit]);
         end
      end
   end

   GrantExclusive: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      !(PageWriteStart && StatusWriteStart));

   // A status write always starts a timed cycle in the array controller
   StatusCycleRuns: assert property (@(posedge SCK) disable iff (RstWriteEnable)
      StatusWriteStart |=> WriteActive && !WriteEnable);

endmodule

`default_nettype wire
